/* logic/axi_cfg_pkg.sv */
// AXI bus configuration
`default_nettype none

package axi_cfg_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Bus geometry
  ////////////////////////////////////////////////////////////////////////////

  // Address and data bus widths
  localparam int unsigned AxiAddrWidth = 32;
  localparam int unsigned AxiDataWidth = 64;

  // One beat always carries the full data bus
  localparam int unsigned AxiBeatBytes = AxiDataWidth / 8;
  // AxSIZE of a full-width beat
  localparam int unsigned AxiSizeFull  = $clog2(AxiBeatBytes);

  ////////////////////////////////////////////////////////////////////////////
  // Burst limits
  ////////////////////////////////////////////////////////////////////////////

  // 4 KiB pages, no burst may cross one
  localparam int unsigned PageBits      = 12;
  // AXI4 INCR bursts are at most 256 beats
  localparam int unsigned MaxBurstBeats = 256;

  // AxBURST encoding for incrementing bursts
  localparam logic [1:0] AxiBurstIncr = 2'b01;

  typedef logic [AxiAddrWidth-1:0] axi_addr_t;

  // Address channel payload, shared by AR and AW
  typedef struct packed {
    axi_addr_t  addr;
    // Beats minus one
    logic [7:0] len;
    logic [2:0] size;
    logic [1:0] burst;
  } axi_ax_t;

endpackage

`default_nettype wire

/* logic/vlsu_pkg.sv */
// Vector load/store definitions
`default_nettype none

package vlsu_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Instruction encodings
  ////////////////////////////////////////////////////////////////////////////

  // Unit-stride and strided loads and stores
  typedef enum logic [1:0] {
    VLE,
    VSE,
    VLSE,
    VSSE
  } vinsn_op_e;

  // Element width as log2 of the element bytes
  typedef enum logic [1:0] {
    EW8,
    EW16,
    EW32,
    EW64
  } vew_e;

  // Element count and byte stride
  typedef logic [15:0]        vlen_t;
  typedef logic signed [31:0] elen_t;

  ////////////////////////////////////////////////////////////////////////////
  // Request, descriptor and command
  ////////////////////////////////////////////////////////////////////////////

  // Incoming vector memory request
  typedef struct packed {
    vinsn_op_e              op;
    axi_cfg_pkg::axi_addr_t addr;
    vlen_t                  vl;
    elen_t                  stride;
    vew_e                   vew;
  } vinsn_req_t;

  // Checked request as seen by the burst splitter
  typedef struct packed {
    axi_cfg_pkg::axi_addr_t addr;
    // Elements still to request
    vlen_t                  vl;
    elen_t                  stride;
    vew_e                   vew;
    logic                   is_load;
    logic                   is_burst;
  } addr_desc_t;

  // One issued AXI request, as told to the load/store unit
  typedef struct packed {
    axi_cfg_pkg::axi_addr_t addr;
    logic [7:0]             len;
    logic [2:0]             size;
    logic                   is_load;
  } lsu_cmd_t;

  // Command queue sizing
  localparam int unsigned LsuQueueDepth    = 4;
  localparam int unsigned LsuQueuePtrWidth = $clog2(LsuQueueDepth);

endpackage

`default_nettype wire

/* logic/vinsn_frontend.sv */
// Vector memory request frontend
`default_nettype none
`timescale 1ns/100ps

module vinsn_frontend (
  input  wire logic                   clk_i,
  input  wire logic                   rst_ni,
  // Incoming request
  input  wire vlsu_pkg::vinsn_req_t   req_i,
  input  wire logic                   req_valid_i,
  output logic                        req_ready_o,
  // Descriptor toward the burst splitter
  output vlsu_pkg::addr_desc_t        desc_o,
  output logic                        desc_valid_o,
  input  wire logic                   desc_done_i,
  // Completion
  output logic                        ack_o,
  output logic                        error_o
);

  import vlsu_pkg::*;
  import axi_cfg_pkg::*;

  // IDLE   waits for a request
  // CHECK  tests the alignment of the registered request
  // ISSUE  holds the descriptor until the splitter is done
  // ACK    closes the request
  typedef enum logic [1:0] {
    IDLE,
    CHECK,
    ISSUE,
    ACK
  } state_e;

  state_e     state_q, state_d;
  vinsn_req_t req_q;
  axi_addr_t  align_mask;
  logic       misaligned;

  // Accept only while nothing is in flight
  assign req_ready_o = (state_q == IDLE);

  // Request register, loaded on the handshake
  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_ready_o) begin
      req_q <= req_i;
    end
  end

  // Address bits below the element width must be zero
  assign align_mask = (axi_addr_t'(1) << req_q.vew) - axi_addr_t'(1);
  assign misaligned = |(req_q.addr & align_mask);

  // Unit-stride ops become bursts, loads go to AR
  assign desc_o = '{
    addr:     req_q.addr,
    vl:       req_q.vl,
    stride:   req_q.stride,
    vew:      req_q.vew,
    is_load:  (req_q.op inside {VLE, VLSE}),
    is_burst: (req_q.op inside {VLE, VSE})
  };

  ////////////////////////////////////////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d      = state_q;
    desc_valid_o = 1'b0;
    ack_o        = 1'b0;
    error_o      = 1'b0;

    unique case (state_q)
      IDLE: begin
        if (req_valid_i) begin
          state_d = CHECK;
        end
      end
      CHECK: begin
        // Misaligned requests fail at once, nothing goes out
        if (misaligned) begin
          ack_o   = 1'b1;
          error_o = 1'b1;
          state_d = IDLE;
        end else begin
          desc_valid_o = 1'b1;
          state_d      = ISSUE;
        end
      end
      ISSUE: begin
        desc_valid_o = 1'b1;
        if (desc_done_i) begin
          state_d = ACK;
        end
      end
      ACK: begin
        ack_o   = 1'b1;
        state_d = IDLE;
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // The splitter finishes only a descriptor that was handed to it
  desc_done_in_issue_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    desc_done_i |-> (state_q == ISSUE)
  );

endmodule

`default_nettype wire

/* logic/burst_splitter.sv */
// AXI request splitter
`default_nettype none
`timescale 1ns/100ps

module burst_splitter (
  input  wire logic                   clk_i,
  input  wire logic                   rst_ni,
  // Descriptor from the frontend
  input  wire vlsu_pkg::addr_desc_t   desc_i,
  input  wire logic                   desc_valid_i,
  output logic                        desc_done_o,
  // AR channel
  output axi_cfg_pkg::axi_ax_t        ar_o,
  output logic                        ar_valid_o,
  input  wire logic                   ar_ready_i,
  // AW channel
  output axi_cfg_pkg::axi_ax_t        aw_o,
  output logic                        aw_valid_o,
  input  wire logic                   aw_ready_i,
  // Command queue
  output vlsu_pkg::lsu_cmd_t          cmd_o,
  output logic                        cmd_push_o,
  input  wire logic                   queue_full_i,
  input  wire vlsu_pkg::lsu_cmd_t     queue_head_i,
  input  wire logic                   queue_empty_i
);

  import vlsu_pkg::*;
  import axi_cfg_pkg::*;

  // One extra bit so page and burst limits do not wrap at the top
  typedef logic [AxiAddrWidth:0] addr_wide_t;

  typedef enum logic {
    IDLE,
    REQUESTING
  } state_e;

  // Start of the burst after the one at addr
  // Earliest of transfer end, 256 beats and page end
  function automatic axi_addr_t next_burst_start(axi_addr_t addr, vlen_t vl, vew_e vew);
    addr_wide_t beat_mask;
    addr_wide_t xfer_last;
    addr_wide_t xfer_next;
    addr_wide_t page_next;
    addr_wide_t limit;
    beat_mask = addr_wide_t'(AxiBeatBytes - 1);
    // Last byte still to transfer, rounded up to the next beat
    xfer_last = addr_wide_t'(addr) + (addr_wide_t'(vl) << vew) - addr_wide_t'(1);
    xfer_next = (xfer_last & ~beat_mask) + addr_wide_t'(AxiBeatBytes);
    // Burst cap counts from the bus-aligned start
    limit     = (addr_wide_t'(addr) & ~beat_mask)
              + addr_wide_t'(MaxBurstBeats * AxiBeatBytes);
    page_next = ((addr_wide_t'(addr) >> PageBits) + addr_wide_t'(1)) << PageBits;
    if (xfer_next < limit) begin
      limit = xfer_next;
    end
    if (page_next < limit) begin
      limit = page_next;
    end
    return limit[AxiAddrWidth-1:0];
  endfunction

  state_e     state_q, state_d;
  addr_desc_t desc_q, desc_d;
  // Window of the burst at desc_q.addr
  axi_addr_t  start_q, start_d;
  axi_addr_t  end_q, end_d;
  axi_addr_t  next_q, next_d;
  axi_ax_t    ax;
  logic       order_ok;
  logic       issue;
  logic       fire;
  axi_addr_t  covered;
  axi_addr_t  covered_elems;

  ////////////////////////////////////////////////////////////////////////////
  // Request build
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    ax.addr  = desc_q.addr;
    ax.burst = AxiBurstIncr;
    if (desc_q.is_burst) begin
      // Full-width beats over the aligned window
      ax.len  = 8'((end_q - start_q) >> AxiSizeFull);
      ax.size = 3'(AxiSizeFull);
    end else begin
      // One element per request
      ax.len  = 8'd0;
      ax.size = {1'b0, desc_q.vew};
    end
  end

  // Queue holds one direction at a time, so this never falls while valid waits
  assign order_ok = queue_empty_i || (queue_head_i.is_load == desc_q.is_load);
  assign issue    = (state_q == REQUESTING) && !queue_full_i && order_ok;

  assign ar_o       = ax;
  assign aw_o       = ax;
  assign ar_valid_o = issue && desc_q.is_load;
  assign aw_valid_o = issue && !desc_q.is_load;
  assign fire       = (ar_valid_o && ar_ready_i) || (aw_valid_o && aw_ready_i);

  // Same request goes to the load/store unit on the handshake
  assign cmd_o = '{
    addr:    ax.addr,
    len:     ax.len,
    size:    ax.size,
    is_load: desc_q.is_load
  };
  assign cmd_push_o = fire;

  // Bytes and elements covered by the current burst
  assign covered       = next_q - desc_q.addr;
  assign covered_elems = covered >> desc_q.vew;

  ////////////////////////////////////////////////////////////////////////////
  // Splitter FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d     = state_q;
    desc_d      = desc_q;
    desc_done_o = 1'b0;

    unique case (state_q)
      IDLE: begin
        if (desc_valid_i) begin
          desc_d  = desc_i;
          state_d = REQUESTING;
        end
      end
      REQUESTING: begin
        if (fire) begin
          if (desc_q.is_burst) begin
            // Continue at the next aligned beat
            desc_d.addr = next_q;
            if (axi_addr_t'(desc_q.vl) <= covered_elems) begin
              desc_d.vl = '0;
            end else begin
              desc_d.vl = desc_q.vl - vlen_t'(covered_elems);
            end
          end else begin
            desc_d.addr = desc_q.addr + axi_addr_t'(desc_q.stride);
            desc_d.vl   = desc_q.vl - vlen_t'(1);
          end
          // Last request of the descriptor
          if (desc_d.vl == '0) begin
            desc_done_o = 1'b1;
            state_d     = IDLE;
          end
        end
      end
      default: state_d = IDLE;
    endcase
  end

  // Window for whatever address comes next
  always_comb begin
    start_d = desc_d.addr & ~axi_addr_t'(AxiBeatBytes - 1);
    next_d  = next_burst_start(desc_d.addr, desc_d.vl, desc_d.vew);
    end_d   = next_d - axi_addr_t'(1);
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    desc_q  <= desc_d;
    start_q <= start_d;
    end_q   <= end_d;
    next_q  <= next_d;
  end

  // AXI rule, valid and payload hold until ready
  ar_hold_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_o)
  );

  aw_hold_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    aw_valid_o && !aw_ready_i |=> aw_valid_o && $stable(aw_o)
  );

  // Frontend never hands over an empty vector
  desc_vl_nonzero_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    desc_valid_i |-> (desc_i.vl != '0)
  );

endmodule

`default_nettype wire

/* logic/lsu_cmd_queue.sv */
// Load/store command queue
`default_nettype none
`timescale 1ns/100ps

module lsu_cmd_queue (
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  // Write side, from the splitter
  input  wire vlsu_pkg::lsu_cmd_t   cmd_i,
  input  wire logic                 push_i,
  output logic                      full_o,
  // Read side, toward the load/store unit
  output vlsu_pkg::lsu_cmd_t        head_o,
  output logic                      empty_o,
  input  wire logic                 pop_i
);

  import vlsu_pkg::*;

  lsu_cmd_t                    mem_q [LsuQueueDepth];
  logic [LsuQueuePtrWidth-1:0] wr_ptr_q, rd_ptr_q;
  // Entries held, one bit wider than the pointers
  logic [LsuQueuePtrWidth:0]   usage_q;

  // Pointer step with wrap at the depth
  function automatic logic [LsuQueuePtrWidth-1:0] ptr_inc(logic [LsuQueuePtrWidth-1:0] ptr);
    if (ptr == LsuQueuePtrWidth'(LsuQueueDepth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full_o  = (usage_q == (LsuQueuePtrWidth + 1)'(LsuQueueDepth));
  assign empty_o = (usage_q == '0);
  assign head_o  = mem_q[rd_ptr_q];

  // Storage
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= cmd_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      usage_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop_i) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      // Simultaneous push and pop keep the count
      if (push_i && !pop_i) begin
        usage_q <= usage_q + 1'b1;
      end else if (pop_i && !push_i) begin
        usage_q <= usage_q - 1'b1;
      end
    end
  end

  // Splitter must respect full, consumer must respect empty
  no_push_full_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni) push_i |-> !full_o
  );

  no_pop_empty_a: assert property (
    @(posedge clk_i) disable iff (!rst_ni) pop_i |-> !empty_o
  );

endmodule

`default_nettype wire

/* logic/addrgen_top.sv */
// Vector address generator
`default_nettype none
`timescale 1ns/100ps

module addrgen_top (
  input  wire logic                   clk_i,
  input  wire logic                   rst_ni,
  // Vector memory requests
  input  wire vlsu_pkg::vinsn_req_t   req_i,
  input  wire logic                   req_valid_i,
  output logic                        req_ready_o,
  output logic                        ack_o,
  output logic                        error_o,
  // AXI address channels
  output axi_cfg_pkg::axi_ax_t        ar_o,
  output logic                        ar_valid_o,
  input  wire logic                   ar_ready_i,
  output axi_cfg_pkg::axi_ax_t        aw_o,
  output logic                        aw_valid_o,
  input  wire logic                   aw_ready_i,
  // Commands to the load/store unit
  output vlsu_pkg::lsu_cmd_t          lsu_cmd_o,
  output logic                        lsu_valid_o,
  input  wire logic                   lsu_ready_i
);

  import vlsu_pkg::*;

  // Frontend to splitter
  addr_desc_t desc;
  logic       desc_valid;
  logic       desc_done;

  // Splitter to queue
  lsu_cmd_t   cmd;
  logic       cmd_push;
  logic       queue_full;
  logic       queue_empty;
  logic       queue_pop;

  assign lsu_valid_o = !queue_empty;
  // Pop only entries that are there
  assign queue_pop   = lsu_ready_i && lsu_valid_o;

  vinsn_frontend i_frontend (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (req_i),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .desc_o       (desc),
    .desc_valid_o (desc_valid),
    .desc_done_i  (desc_done),
    .ack_o        (ack_o),
    .error_o      (error_o)
  );

  // Head of the queue feeds back for channel ordering
  burst_splitter i_splitter (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .desc_i        (desc),
    .desc_valid_i  (desc_valid),
    .desc_done_o   (desc_done),
    .ar_o          (ar_o),
    .ar_valid_o    (ar_valid_o),
    .ar_ready_i    (ar_ready_i),
    .aw_o          (aw_o),
    .aw_valid_o    (aw_valid_o),
    .aw_ready_i    (aw_ready_i),
    .cmd_o         (cmd),
    .cmd_push_o    (cmd_push),
    .queue_full_i  (queue_full),
    .queue_head_i  (lsu_cmd_o),
    .queue_empty_i (queue_empty)
  );

  lsu_cmd_queue i_cmd_queue (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .cmd_i   (cmd),
    .push_i  (cmd_push),
    .full_o  (queue_full),
    .head_o  (lsu_cmd_o),
    .empty_o (queue_empty),
    .pop_i   (queue_pop)
  );

endmodule

`default_nettype wire

/* verif/addrgen_checker.sv */
// Address generator checker
`default_nettype none
`timescale 1ns/100ps

module addrgen_checker (
  input  wire logic                   clk_i,
  input  wire logic                   rst_ni,
  // Request side of the DUT
  input  wire vlsu_pkg::vinsn_req_t   req_i,
  input  wire logic                   req_valid_i,
  input  wire logic                   req_ready_i,
  input  wire logic                   ack_i,
  input  wire logic                   error_i,
  // AXI address channels
  input  wire axi_cfg_pkg::axi_ax_t   ar_i,
  input  wire logic                   ar_valid_i,
  input  wire logic                   ar_ready_i,
  input  wire axi_cfg_pkg::axi_ax_t   aw_i,
  input  wire logic                   aw_valid_i,
  input  wire logic                   aw_ready_i,
  // Queue output
  input  wire vlsu_pkg::lsu_cmd_t     lsu_cmd_i,
  input  wire logic                   lsu_valid_i,
  input  wire logic                   lsu_ready_i,
  // Results for the testbench top
  output int unsigned                 err_count_o,
  output int unsigned                 issued_o,
  output int unsigned                 pending_o
);

  import vlsu_pkg::*;
  import axi_cfg_pkg::*;

  // Expected traffic, filled when a request is accepted
  axi_ax_t     exp_ar [$];
  axi_ax_t     exp_aw [$];
  lsu_cmd_t    exp_lsu [$];
  logic        exp_err [$];

  int unsigned errors = 0;
  int unsigned issued = 0;
  int unsigned pending = 0;

  // Channel hold tracking between samples
  logic        ar_wait_q;
  logic        aw_wait_q;
  axi_ax_t     ar_held_q;
  axi_ax_t     aw_held_q;

  assign err_count_o = errors;
  assign issued_o    = issued;
  assign pending_o   = pending;

  task automatic report_value(string name, logic [63:0] exp, logic [63:0] act);
    $display("Error at %0t: %s expected %h actual %h", $time, name, exp, act);
    errors++;
  endtask

  task automatic report_failure(string what);
    $display("Failure at %0t: %s", $time, what);
    errors++;
  endtask

  // Queue an expected request on its channel and toward the LSU
  function automatic void expect_cmd(axi_ax_t ax, logic is_load);
    lsu_cmd_t c;
    c.addr    = ax.addr;
    c.len     = ax.len;
    c.size    = ax.size;
    c.is_load = is_load;
    if (is_load) begin
      exp_ar.push_back(ax);
    end else begin
      exp_aw.push_back(ax);
    end
    exp_lsu.push_back(c);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic void expand_request(vinsn_req_t r);
    int unsigned       eb;
    int unsigned       vl_left;
    int unsigned       elems;
    longint unsigned   cur;
    longint unsigned   beat_start;
    longint unsigned   stop;
    longint unsigned   lim;
    logic              is_load;
    axi_ax_t           ax;
    eb      = 1 << r.vew;
    is_load = (r.op == VLE) || (r.op == VLSE);
    // Misaligned base, only a failed ack
    if ((r.addr % eb) != 0) begin
      exp_err.push_back(1'b1);
      return;
    end
    exp_err.push_back(1'b0);
    ax.burst = 2'b01;
    if ((r.op == VLE) || (r.op == VSE)) begin
      cur     = r.addr;
      vl_left = r.vl;
      while (vl_left > 0) begin
        beat_start = cur - (cur % AxiBeatBytes);
        // End of transfer, rounded up to a whole beat
        stop = cur + longint'(vl_left) * eb;
        stop = ((stop + AxiBeatBytes - 1) / AxiBeatBytes) * AxiBeatBytes;
        // 256 beats from the aligned start
        lim = beat_start + longint'(MaxBurstBeats) * AxiBeatBytes;
        if (lim < stop) begin
          stop = lim;
        end
        // Next 4 KiB page boundary
        lim = ((cur >> PageBits) + 1) << PageBits;
        if (lim < stop) begin
          stop = lim;
        end
        ax.addr = axi_addr_t'(cur);
        ax.len  = 8'((stop - beat_start) / AxiBeatBytes - 1);
        ax.size = 3'($clog2(AxiBeatBytes));
        expect_cmd(ax, is_load);
        elems   = int'((stop - cur) / eb);
        vl_left = (elems >= vl_left) ? 0 : vl_left - elems;
        cur     = stop;
      end
    end else begin
      // One element per request at base plus k strides
      for (int unsigned k = 0; k < r.vl; k++) begin
        ax.addr = r.addr + axi_addr_t'(longint'(k) * longint'(r.stride));
        ax.len  = 8'd0;
        ax.size = {1'b0, r.vew};
        expect_cmd(ax, is_load);
      end
    end
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Monitor, sampled mid-cycle
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin
    axi_ax_t  ax;
    lsu_cmd_t c;
    logic     e;
    if (!rst_ni) begin
      // Idle outputs under reset
      if (req_ready_i !== 1'b1) report_value("req_ready_o", 64'd1, 64'(req_ready_i));
      if (ack_i !== 1'b0) report_value("ack_o", 64'd0, 64'(ack_i));
      if (error_i !== 1'b0) report_value("error_o", 64'd0, 64'(error_i));
      if (ar_valid_i !== 1'b0) report_value("ar_valid_o", 64'd0, 64'(ar_valid_i));
      if (aw_valid_i !== 1'b0) report_value("aw_valid_o", 64'd0, 64'(aw_valid_i));
      if (lsu_valid_i !== 1'b0) report_value("lsu_valid_o", 64'd0, 64'(lsu_valid_i));
      ar_wait_q = 1'b0;
      aw_wait_q = 1'b0;
    end else begin
      if ((exp_err.size() != 0) && req_ready_i) begin
        report_failure("req_ready_o high while a request is in flight");
      end
      if (req_valid_i && req_ready_i) begin
        expand_request(req_i);
      end
      // Completion
      if (ack_i) begin
        if (exp_err.size() == 0) begin
          report_failure("ack_o pulsed with no request outstanding");
        end else begin
          e = exp_err.pop_front();
          if (error_i !== e) report_value("error_o", 64'(e), 64'(error_i));
          if (!e && ((exp_ar.size() != 0) || (exp_aw.size() != 0))) begin
            report_failure("ack_o came before all AXI requests were issued");
          end
        end
      end else if (error_i) begin
        report_failure("error_o high without ack_o");
      end
      // Channel ordering against the queue head
      if (ar_valid_i && ar_ready_i && lsu_valid_i && !lsu_cmd_i.is_load) begin
        report_failure("load issued on AR while the queue head is a store");
      end
      if (aw_valid_i && aw_ready_i && lsu_valid_i && lsu_cmd_i.is_load) begin
        report_failure("store issued on AW while the queue head is a load");
      end
      if (ar_valid_i && ar_ready_i) begin
        issued++;
        if (exp_ar.size() == 0) begin
          report_failure("AR handshake with no load request expected");
        end else begin
          ax = exp_ar.pop_front();
          if (ar_i !== ax) report_value("ar_o", 64'(ax), 64'(ar_i));
        end
      end
      if (aw_valid_i && aw_ready_i) begin
        issued++;
        if (exp_aw.size() == 0) begin
          report_failure("AW handshake with no store request expected");
        end else begin
          ax = exp_aw.pop_front();
          if (aw_i !== ax) report_value("aw_o", 64'(ax), 64'(aw_i));
        end
      end
      // Queue pops follow handshake order
      if (lsu_valid_i && lsu_ready_i) begin
        if (exp_lsu.size() == 0) begin
          report_failure("queue popped with no command expected");
        end else begin
          c = exp_lsu.pop_front();
          if (lsu_cmd_i !== c) report_value("lsu_cmd_o", 64'(c), 64'(lsu_cmd_i));
        end
      end
      // Valid and payload held until ready
      if (ar_wait_q && ((ar_valid_i !== 1'b1) || (ar_i !== ar_held_q))) begin
        report_failure("AR valid or payload changed before ready");
      end
      if (aw_wait_q && ((aw_valid_i !== 1'b1) || (aw_i !== aw_held_q))) begin
        report_failure("AW valid or payload changed before ready");
      end
      ar_wait_q = ar_valid_i && !ar_ready_i;
      aw_wait_q = aw_valid_i && !aw_ready_i;
      ar_held_q = ar_i;
      aw_held_q = aw_i;
    end
    pending = exp_ar.size() + exp_aw.size() + exp_lsu.size() + exp_err.size();
  end

endmodule

`default_nettype wire

/* verif/tb_addrgen.sv */
// Address generator testbench
`default_nettype none
`timescale 1ns/100ps

module tb_addrgen;

  import vlsu_pkg::*;
  import axi_cfg_pkg::*;

  localparam int unsigned ClkPeriod   = 100;
  localparam int unsigned NumRequests = 150;
  localparam int unsigned MaxVl       = 300;
  // Generous bound on cycles per beat under random ready
  localparam int unsigned CyclesPerBeat = 16;
  localparam longint      WatchdogCycles =
    longint'(NumRequests) * (MaxVl * CyclesPerBeat + 32) + 64;
  localparam logic [31:0] Seed     = 32'd76123;
  // x^32 + x^22 + x^2 + x + 1
  localparam logic [31:0] LfsrTaps = 32'h8020_0003;

  logic        clk_i  = 1'b0;
  logic        rst_ni = 1'b0;
  vinsn_req_t  req_i;
  logic        req_valid_i;
  logic        req_ready_o;
  logic        ack_o;
  logic        error_o;
  axi_ax_t     ar_o;
  logic        ar_valid_o;
  logic        ar_ready_i;
  axi_ax_t     aw_o;
  logic        aw_valid_o;
  logic        aw_ready_i;
  lsu_cmd_t    lsu_cmd_o;
  logic        lsu_valid_o;
  logic        lsu_ready_i;

  // Checker results
  int unsigned err_count;
  int unsigned issued;
  int unsigned pending;

  logic [31:0] lfsr_state;

  initial begin
    forever begin
      #(ClkPeriod / 2);
      clk_i = ~clk_i;
    end
  end

  addrgen_top addrgen_top_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (req_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .ack_o       (ack_o),
    .error_o     (error_o),
    .ar_o        (ar_o),
    .ar_valid_o  (ar_valid_o),
    .ar_ready_i  (ar_ready_i),
    .aw_o        (aw_o),
    .aw_valid_o  (aw_valid_o),
    .aw_ready_i  (aw_ready_i),
    .lsu_cmd_o   (lsu_cmd_o),
    .lsu_valid_o (lsu_valid_o),
    .lsu_ready_i (lsu_ready_i)
  );

  addrgen_checker addrgen_checker_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (req_i),
    .req_valid_i (req_valid_i),
    .req_ready_i (req_ready_o),
    .ack_i       (ack_o),
    .error_i     (error_o),
    .ar_i        (ar_o),
    .ar_valid_i  (ar_valid_o),
    .ar_ready_i  (ar_ready_i),
    .aw_i        (aw_o),
    .aw_valid_i  (aw_valid_o),
    .aw_ready_i  (aw_ready_i),
    .lsu_cmd_i   (lsu_cmd_o),
    .lsu_valid_i (lsu_valid_o),
    .lsu_ready_i (lsu_ready_i),
    .err_count_o (err_count),
    .issued_o    (issued),
    .pending_o   (pending)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Random source
  ////////////////////////////////////////////////////////////////////////////

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] take_bits(int unsigned n);
    logic [31:0] val;
    int unsigned i;
    val = '0;
    for (i = 0; i < n; i++) begin
      val        = {val[30:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ LfsrTaps) : (lfsr_state >> 1);
    end
    return val;
  endfunction

  function automatic vinsn_req_t build_request();
    vinsn_req_t  r;
    logic [31:0] bits;
    axi_addr_t   mask;
    bits     = take_bits(2);
    r.op     = vinsn_op_e'(bits[1:0]);
    bits     = take_bits(2);
    r.vew    = vew_e'(bits[1:0]);
    r.vl     = vlen_t'(take_bits(9) % MaxVl + 1);
    bits     = take_bits(12);
    r.stride = elen_t'($signed(bits[11:0]));
    mask     = (axi_addr_t'(1) << r.vew) - axi_addr_t'(1);
    r.addr   = axi_addr_t'(take_bits(22)) & ~mask;
    bits     = take_bits(3);
    if ((bits == 0) && (r.vew != EW8)) begin
      // Off by one byte
      r.addr = r.addr | axi_addr_t'(1);
    end else if (bits < 3) begin
      // A few elements before the end of the page
      r.addr = (r.addr | axi_addr_t'(12'hFFF)) + axi_addr_t'(1)
             - (axi_addr_t'(take_bits(5) + 1) << r.vew);
    end
    return r;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Watchdog and stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    #(WatchdogCycles * ClkPeriod);
    $display("Watchdog expired before all requests completed");
    $display("Finished with errors");
    $finish;
  end

  initial begin
    logic        hs_pending;
    logic        waiting_ack;
    int unsigned sent;
    req_i       = '0;
    req_valid_i = 1'b0;
    ar_ready_i  = 1'b0;
    aw_ready_i  = 1'b0;
    lsu_ready_i = 1'b0;
    lfsr_state  = Seed;
    hs_pending  = 1'b0;
    waiting_ack = 1'b0;
    sent        = 0;
    repeat (5) @(posedge clk_i);
    #10;
    rst_ni = 1'b1;
    // Run until every request is acked and the queue is drained
    while ((sent < NumRequests) || req_valid_i || waiting_ack || (pending != 0)) begin
      @(posedge clk_i);
      #10;
      ar_ready_i  = |take_bits(2);
      aw_ready_i  = |take_bits(2);
      lsu_ready_i = |take_bits(2);
      // Handshake took place on this edge
      if (hs_pending) begin
        req_valid_i = 1'b0;
        waiting_ack = 1'b1;
      end
      if (ack_o) begin
        waiting_ack = 1'b0;
      end
      if (!req_valid_i && !waiting_ack && (sent < NumRequests)) begin
        req_i       = build_request();
        req_valid_i = 1'b1;
        sent++;
      end
      // Ready depends on state only, so it holds until the next edge
      hs_pending = req_valid_i && req_ready_o;
    end
    // Catch stray activity after the last command
    repeat (4) @(posedge clk_i);
    $display("Sent %0d requests, saw %0d AXI requests, %0d errors", sent, issued, err_count);
    if (err_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
logic/axi_cfg_pkg.sv
logic/vlsu_pkg.sv
logic/vinsn_frontend.sv
logic/burst_splitter.sv
logic/lsu_cmd_queue.sv
logic/addrgen_top.sv
verif/addrgen_checker.sv
verif/tb_addrgen.sv

/* Bender.yml */
package:
  name: addrgen

sources:
  - logic/axi_cfg_pkg.sv
  - logic/vlsu_pkg.sv
  - logic/vinsn_frontend.sv
  - logic/burst_splitter.sv
  - logic/lsu_cmd_queue.sv
  - logic/addrgen_top.sv
  - target: test
    files:
      - verif/addrgen_checker.sv
      - verif/tb_addrgen.sv
